// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --assert
TOP       = tb_exeStage
FILELIST  = tb.f
OBJDIR    = obj_dir
PASS_MSG  = === PASS ===

BIN  = $(OBJDIR)/V$(TOP)
SRCS = $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(BIN)

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

// ==== alu.sv ====
module alu (
    exeBundle_if.alu           bus,
    output rvTypes_pkg::word_t result,
    output logic               btaken
);
    import rvTypes_pkg::*;
    import rvOps_pkg::*;

    logic [4:0] shamt;
    logic       resZero;

    assign shamt = bus.opB[4:0];  // RV32I uses only the low five bits

    always_comb
    begin
        case (bus.aluFn)
            ADD:
            begin
                result = bus.opA + bus.opB;
            end
            SUB:
            begin
                result = bus.opA - bus.opB;
            end
            SLL:
            begin
                result = bus.opA << shamt;
            end
            SLT:
            begin
                result = word_t'($signed(bus.opA) < $signed(bus.opB));
            end
            SLTU:
            begin
                result = word_t'(bus.opA < bus.opB);
            end
            XOR:
            begin
                result = bus.opA ^ bus.opB;
            end
            SRL:
            begin
                result = bus.opA >> shamt;
            end
            SRA:
            begin
                result = word_t'($signed(bus.opA) >>> shamt);  // sign fill
            end
            OR:
            begin
                result = bus.opA | bus.opB;
            end
            AND:
            begin
                result = bus.opA & bus.opB;
            end
            default:
            begin
                result = '0;
            end
        endcase
    end

    assign resZero = (result == '0);

    // beq/bge style use a zero result, bne/blt style a nonzero one
    assign btaken = bus.btype && (bus.bneq ? !resZero : resZero);

endmodule

// ==== branchUnit.sv ====
module branchUnit (
    exeBundle_if.branch        bus,
    input  logic               btaken,
    output rvTypes_pkg::word_t target
);
    import rvTypes_pkg::*;

    word_t jrSum;
    word_t jSum;
    word_t bSum;
    word_t seqPc;

    assign jrSum = bus.opA + bus.opB;    // rs1 + I immediate
    assign jSum  = bus.pc + bus.jImm;
    assign bSum  = bus.pc + bus.bImm;
    assign seqPc = bus.pc + word_t'(INSTR_BYTES);

    // jalr first, then jal, then a taken branch
    always_comb
    begin
        if (bus.jr)
        begin
            target = {jrSum[XLEN-1:1], 1'b0};  // jalr clears bit 0
        end
        else if (bus.j)
        begin
            target = jSum;
        end
        else if (btaken)
        begin
            target = bSum;
        end
        else
        begin
            target = seqPc;
        end
    end

endmodule

// ==== dataMemPort.sv ====
module dataMemPort (
    input  logic               clk,
    input  logic               nrst,
    input  rvOps_pkg::memOp_t  memOp4,
    input  rvTypes_pkg::word_t opA4,
    input  rvTypes_pkg::word_t opB4,   // store data, or load offset
    input  rvTypes_pkg::word_t sImm4,  // store offset
    output rvTypes_pkg::word_t memOut6,
    output logic               addrMisaligned6
);
    import rvTypes_pkg::*;
    import rvOps_pkg::*;

    memOp_t   memOp5;
    word_t    addr5;
    word_t    sData5;
    dmemIdx_t idx5;
    logic     misaligned5;
    byteEn_t  be5;
    word_t    wData5;
    word_t    rWord5;
    word_t    rShift5;
    logic [7:0]  rByte5;
    logic [15:0] rHalf5;
    word_t    ldData5;

    word_t mem [DMEM_WORDS];

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            memOp5 <= NONE;
        end
        else
        begin
            memOp5 <= memOp4;
        end
    end

    always_ff @(posedge clk)
    begin
        addr5  <= isStore(memOp4) ? opA4 + sImm4 : opA4 + opB4;
        sData5 <= opB4;
    end

    assign idx5 = addr5[DMEM_IDX_W+1:2];  // wraps over the memory size
    assign misaligned5 = (isHalf(memOp5) && addr5[0]) ||
                         (isWord(memOp5) && (addr5[1:0] != 2'b00));

    // replicate store data over the lanes it may land in
    always_comb
    begin
        case (memOp5)
            SB:
            begin
                be5    = byteEn_t'(1) << addr5[1:0];
                wData5 = {4{sData5[7:0]}};
            end
            SH:
            begin
                be5    = addr5[1] ? 4'b1100 : 4'b0011;
                wData5 = {2{sData5[15:0]}};
            end
            SW:
            begin
                be5    = '1;
                wData5 = sData5;
            end
            default:
            begin
                be5    = '0;
                wData5 = sData5;
            end
        endcase
    end

    // a store one cycle ahead has already landed here
    assign rWord5  = mem[idx5];
    assign rShift5 = rWord5 >> {addr5[1:0], 3'b000};
    assign rByte5  = rShift5[7:0];
    assign rHalf5  = addr5[1] ? rWord5[31:16] : rWord5[15:0];

    always_comb
    begin
        case (memOp5)
            LB:      ldData5 = {{24{rByte5[7]}}, rByte5};
            LH:      ldData5 = {{16{rHalf5[15]}}, rHalf5};
            LBU:     ldData5 = {24'b0, rByte5};
            LHU:     ldData5 = {16'b0, rHalf5};
            default: ldData5 = rWord5;   // LW
        endcase
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < DMEM_WORDS; i++)
            begin
                mem[i] <= '0;
            end
        end
        else if (isStore(memOp5) && !misaligned5)
        begin
            for (int b = 0; b < BYTE_LANES; b++)
            begin
                if (be5[b])
                begin
                    mem[idx5][8*b +: 8] <= wData5[8*b +: 8];
                end
            end
        end
    end

    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            memOut6         <= '0;
            addrMisaligned6 <= 1'b0;
        end
        else
        begin
            addrMisaligned6 <= misaligned5;
            if (memOp5 == NONE)
            begin
                memOut6 <= '0;
            end
            else if (isLoad(memOp5) && !misaligned5)
            begin
                memOut6 <= ldData5;
            end
        end
    end

endmodule

// ==== exeBundle_if.sv ====
interface exeBundle_if;
    import rvTypes_pkg::*;
    import rvOps_pkg::*;

    word_t  opA;
    word_t  opB;      // rs2 or I-type immediate
    aluFn_t aluFn;
    logic   bneq;     // branch on nonzero result
    logic   btype;    // instruction is a conditional branch
    word_t  pc;
    word_t  bImm;
    word_t  jImm;
    logic   j;        // jal
    logic   jr;       // jalr

    modport src (
        output opA, opB, aluFn, bneq, btype, pc, bImm, jImm, j, jr
    );

    modport alu (
        input opA, opB, aluFn, bneq, btype
    );

    modport branch (
        input opA, opB, pc, bImm, jImm, j, jr
    );

endinterface

// ==== exeStage.sv ====
module exeStage (
    input  logic                  clk,
    input  logic                  nrst,
    input  logic                  we4,
    input  logic                  bneq4,
    input  logic                  btype4,
    input  rvTypes_pkg::funct3_t  fn4,
    input  rvTypes_pkg::regAddr_t rd4,
    input  rvOps_pkg::aluFn_t     aluFn4,
    input  rvTypes_pkg::word_t    opA4,
    input  rvTypes_pkg::word_t    opB4,
    input  rvTypes_pkg::word_t    pc4,
    input  rvTypes_pkg::word_t    bImm4,
    input  rvTypes_pkg::word_t    jImm4,
    input  rvTypes_pkg::word_t    sImm4,
    input  rvTypes_pkg::pcSel_t   pcSelect4,
    input  logic                  j4,
    input  logic                  jr4,
    input  rvOps_pkg::memOp_t     memOp4,
    output logic                  we5,
    output rvTypes_pkg::funct3_t  fn5,
    output rvTypes_pkg::word_t    aluRes5,
    output rvTypes_pkg::regAddr_t rd5,
    output rvTypes_pkg::word_t    target,
    output rvTypes_pkg::pcSel_t   pcSelect5,
    output logic                  j5,
    output logic                  jr5,
    output rvTypes_pkg::word_t    memOut6,
    output logic                  addrMisaligned6
);
    import rvOps_pkg::*;

    exeBundle_if bus ();
    logic btaken;   // alu decision into the branch unit

    // stage-5 pipe register
    always_ff @(posedge clk, negedge nrst)
    begin
        if (!nrst)
        begin
            bus.opA   <= '0;
            bus.opB   <= '0;
            bus.aluFn <= ADD;
            bus.bneq  <= 1'b0;
            bus.btype <= 1'b0;
            bus.pc    <= '0;
            bus.bImm  <= '0;
            bus.jImm  <= '0;
            we5       <= 1'b0;
            fn5       <= '0;
            rd5       <= '0;
            pcSelect5 <= '0;
            j5        <= 1'b0;
            jr5       <= 1'b0;
        end
        else
        begin
            bus.opA   <= opA4;
            bus.opB   <= opB4;
            bus.aluFn <= aluFn4;
            bus.bneq  <= bneq4;
            bus.btype <= btype4;
            bus.pc    <= pc4;
            bus.bImm  <= bImm4;
            bus.jImm  <= jImm4;
            we5       <= we4;       // pass-through to writeback
            fn5       <= fn4;
            rd5       <= rd4;
            pcSelect5 <= pcSelect4;
            j5        <= j4;
            jr5       <= jr4;
        end
    end

    // jump flags are both outputs and branch unit inputs
    assign bus.j  = j5;
    assign bus.jr = jr5;

    alu u_alu (
        .bus    (bus.alu),
        .result (aluRes5),
        .btaken (btaken)
    );

    branchUnit u_branchUnit (
        .bus    (bus.branch),
        .btaken (btaken),
        .target (target)
    );

    // memory port takes stage-4 operands and keeps its own pipe
    dataMemPort u_dataMemPort (
        .clk             (clk),
        .nrst            (nrst),
        .memOp4          (memOp4),
        .opA4            (opA4),
        .opB4            (opB4),
        .sImm4           (sImm4),
        .memOut6         (memOut6),
        .addrMisaligned6 (addrMisaligned6)
    );

endmodule

// ==== exeStage_assert.sv ====
module exeStage_assert (
    input logic                  clk,
    input logic                  nrst,
    input rvTypes_pkg::regAddr_t rd4,
    input rvTypes_pkg::regAddr_t rd5,
    input logic                  we5,
    input logic                  j5,
    input logic                  jr5,
    input rvOps_pkg::memOp_t     memOp4,
    input logic                  addrMisaligned6
);
    import rvOps_pkg::*;

    // pipe held clear while reset is low
    resetClearsFlags: assert property (@(posedge clk) !nrst |-> (!we5 && !j5 && !jr5))
        else $error("we5, j5 or jr5 set while nrst is low");

    rdFollowsIssue: assert property (@(posedge clk) disable iff (!nrst)
        $past(nrst) |-> (rd5 == $past(rd4)))
        else $error("rd5 does not match rd4 of the previous cycle");

    // flag lands two edges after issue
    noFlagWithoutAccess: assert property (@(posedge clk) disable iff (!nrst)
        ($past(memOp4, 2) == NONE) |-> !addrMisaligned6)
        else $error("addrMisaligned6 raised for a NONE memory op");

endmodule

bind exeStage exeStage_assert u_exeStage_assert (
    .clk             (clk),
    .nrst            (nrst),
    .rd4             (rd4),
    .rd5             (rd5),
    .we5             (we5),
    .j5              (j5),
    .jr5             (jr5),
    .memOp4          (memOp4),
    .addrMisaligned6 (addrMisaligned6)
);

// ==== rvOps_pkg.sv ====
package rvOps_pkg;

    // alu operations
    typedef enum logic [3:0] {
        ADD  = 4'd0,   // also the reset value of the pipe
        SUB  = 4'd1,
        SLL  = 4'd2,
        SLT  = 4'd3,
        SLTU = 4'd4,
        XOR  = 4'd5,
        SRL  = 4'd6,
        SRA  = 4'd7,
        OR   = 4'd8,
        AND  = 4'd9
    } aluFn_t;

    // data memory operations
    typedef enum logic [3:0] {
        NONE = 4'd0,
        LB   = 4'd1,
        LH   = 4'd2,
        LW   = 4'd3,
        LBU  = 4'd4,
        LHU  = 4'd5,
        SB   = 4'd6,
        SH   = 4'd7,
        SW   = 4'd8
    } memOp_t;

    function automatic logic isLoad(memOp_t op);
        return op inside {LB, LH, LW, LBU, LHU};
    endfunction

    function automatic logic isStore(memOp_t op);
        return op inside {SB, SH, SW};
    endfunction

    // halfword accesses need addr[0] clear
    function automatic logic isHalf(memOp_t op);
        return op inside {LH, LHU, SH};
    endfunction

    // word accesses need addr[1:0] clear
    function automatic logic isWord(memOp_t op);
        return op inside {LW, SW};
    endfunction

endpackage

// ==== rvTypes_pkg.sv ====
package rvTypes_pkg;

    // datapath widths
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;   // x0..x31
    localparam int FUNCT3_W   = 3;
    localparam int PCSEL_W    = 2;

    // byte lanes in one data word
    localparam int BYTE_LANES = XLEN / 8;

    // sequential fetch step
    localparam int INSTR_BYTES = 4;

    // local data memory
    localparam int DMEM_WORDS = 256;
    localparam int DMEM_IDX_W = $clog2(DMEM_WORDS);  // 8 bits, addr[9:2]

    // data, address or immediate
    typedef logic [XLEN-1:0] word_t;

    // register file index
    typedef logic [REG_ADDR_W-1:0] regAddr_t;

    // instruction funct3 field
    typedef logic [FUNCT3_W-1:0] funct3_t;

    // next-pc source select, decoded upstream
    typedef logic [PCSEL_W-1:0] pcSel_t;

    // word index into the data memory
    typedef logic [DMEM_IDX_W-1:0] dmemIdx_t;

    // store byte enables
    typedef logic [BYTE_LANES-1:0] byteEn_t;

endpackage

// ==== tb.f ====
rvTypes_pkg.sv
rvOps_pkg.sv
exeBundle_if.sv
alu.sv
branchUnit.sv
dataMemPort.sv
exeStage.sv
exeStage_assert.sv
tb_exeStage.sv

// ==== tb_exeStage.sv ====
module tb_exeStage;
    import rvTypes_pkg::*;
    import rvOps_pkg::*;

    typedef struct packed {
        logic     we;
        logic     bneq;
        logic     btype;
        funct3_t  fn;
        regAddr_t rd;
        aluFn_t   aluFn;
        word_t    opA;
        word_t    opB;
        word_t    pc;
        word_t    bImm;
        word_t    jImm;
        word_t    sImm;
        pcSel_t   pcSel;
        logic     j;
        logic     jr;
        memOp_t   memOp;
        word_t    expAlu;      // stage-5 results
        word_t    expTarget;
        word_t    expMem;      // stage-6 results
        logic     expMis;
    } stimRow_t;

    localparam int RESET_CYCLES = 8;
    localparam int RANDOM_ROWS  = 24;

    logic     clk;
    logic     nrst;
    logic     we4;
    logic     bneq4;
    logic     btype4;
    funct3_t  fn4;
    regAddr_t rd4;
    aluFn_t   aluFn4;
    word_t    opA4;
    word_t    opB4;
    word_t    pc4;
    word_t    bImm4;
    word_t    jImm4;
    word_t    sImm4;
    pcSel_t   pcSelect4;
    logic     j4;
    logic     jr4;
    memOp_t   memOp4;
    logic     we5;
    funct3_t  fn5;
    word_t    aluRes5;
    regAddr_t rd5;
    word_t    target;
    pcSel_t   pcSelect5;
    logic     j5;
    logic     jr5;
    word_t    memOut6;
    logic     addrMisaligned6;

    stimRow_t rows[$];
    stimRow_t prev1;
    stimRow_t prev2;
    stimRow_t idleRow;
    word_t    shadow [DMEM_WORDS];   // reference copy of the data memory
    word_t    lastOut;
    int       seed;
    int       cycles;
    int       cycleLimit;

    exeStage u_exeStage (
        .clk             (clk),
        .nrst            (nrst),
        .we4             (we4),
        .bneq4           (bneq4),
        .btype4          (btype4),
        .fn4             (fn4),
        .rd4             (rd4),
        .aluFn4          (aluFn4),
        .opA4            (opA4),
        .opB4            (opB4),
        .pc4             (pc4),
        .bImm4           (bImm4),
        .jImm4           (jImm4),
        .sImm4           (sImm4),
        .pcSelect4       (pcSelect4),
        .j4              (j4),
        .jr4             (jr4),
        .memOp4          (memOp4),
        .we5             (we5),
        .fn5             (fn5),
        .aluRes5         (aluRes5),
        .rd5             (rd5),
        .target          (target),
        .pcSelect5       (pcSelect5),
        .j5              (j5),
        .jr5             (jr5),
        .memOut6         (memOut6),
        .addrMisaligned6 (addrMisaligned6)
    );

    always #2 clk = ~clk;

    always @(posedge clk)
    begin
        cycles = cycles + 1;
        if (cycles > cycleLimit)
        begin
            stopOnError($sformatf("timeout: the run did not end within %0d cycles", cycleLimit));
        end
    end

    task automatic stopOnError(string what);
        $display("%s", what);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic checkWord(string name, word_t got, word_t exp);
        if (got !== exp)
        begin
            stopOnError($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkReg(string name, regAddr_t got, regAddr_t exp);
        if (got !== exp)
        begin
            stopOnError($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkFunct3(string name, funct3_t got, funct3_t exp);
        if (got !== exp)
        begin
            stopOnError($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkPcSel(string name, pcSel_t got, pcSel_t exp);
        if (got !== exp)
        begin
            stopOnError($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkBit(string name, logic got, logic exp);
        if (got !== exp)
        begin
            stopOnError($sformatf("ERROR: %s got 0x%h expected 0x%h", name, got, exp));
        end
    endtask

    function automatic word_t refAlu(aluFn_t fn, word_t a, word_t b);
        int sh;
        sh = int'(b[4:0]);
        case (fn)
            ADD:     return a + b;
            SUB:     return a - b;
            SLL:     return a << sh;
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            SLTU:    return (a < b) ? 32'd1 : 32'd0;
            XOR:     return a ^ b;
            SRL:     return a >> sh;
            SRA:     return (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            OR:      return a | b;
            AND:     return a & b;
            default: return 32'h0;
        endcase
    endfunction

    function automatic word_t refTarget(stimRow_t r);
        word_t res;
        logic  taken;
        res   = refAlu(r.aluFn, r.opA, r.opB);
        taken = r.btype && ((res != 32'h0) == r.bneq);
        if (r.jr)
        begin
            return (r.opA + r.opB) & ~32'h1;
        end
        else if (r.j)
        begin
            return r.pc + r.jImm;
        end
        else if (taken)
        begin
            return r.pc + r.bImm;
        end
        return r.pc + 32'd4;
    endfunction

    // walks the rows in issue order against the shadow memory
    task automatic modelMem(inout stimRow_t r);
        word_t       addr;
        word_t       w;
        dmemIdx_t    idx;
        int          lane;
        int          half;
        logic        mis;
        logic [7:0]  b8;
        logic [15:0] h16;
        addr = (r.memOp inside {SB, SH, SW}) ? r.opA + r.sImm : r.opA + r.opB;
        idx  = addr[DMEM_IDX_W+1:2];
        lane = int'(addr[1:0]);
        half = int'(addr[1]);
        mis  = (r.memOp inside {LH, LHU, SH} && addr[0]) ||
               (r.memOp inside {LW, SW} && addr[1:0] != 2'b00);
        w    = shadow[idx];
        b8   = w[8*lane +: 8];
        h16  = w[16*half +: 16];
        if (r.memOp == NONE)
        begin
            lastOut = 32'h0;
        end
        else if (!mis)
        begin
            case (r.memOp)
                SB:      w[8*lane +: 8] = r.opB[7:0];
                SH:      w[16*half +: 16] = r.opB[15:0];
                SW:      w = r.opB;
                LB:      lastOut = {{24{b8[7]}}, b8};
                LH:      lastOut = {{16{h16[15]}}, h16};
                LW:      lastOut = w;
                LBU:     lastOut = {24'h0, b8};
                LHU:     lastOut = {16'h0, h16};
                default: ;
            endcase
            shadow[idx] = w;
        end
        r.expMem = lastOut;
        r.expMis = mis;
    endtask

    // pass-through fields vary with the row number
    function automatic stimRow_t blankRow();
        stimRow_t r;
        int       n;
        n       = rows.size();
        r       = '0;
        r.aluFn = ADD;
        r.memOp = NONE;
        r.rd    = regAddr_t'(n);
        r.we    = n[0];
        r.fn    = funct3_t'(n);
        r.pcSel = pcSel_t'(n >> 1);
        r.pc    = 32'h1000 + word_t'(n) * 4;
        return r;
    endfunction

    task automatic putAlu(aluFn_t fn, word_t a, word_t b);
        stimRow_t r;
        r       = blankRow();
        r.aluFn = fn;
        r.opA   = a;
        r.opB   = b;
        rows.push_back(r);
    endtask

    task automatic putBranch(aluFn_t fn, word_t a, word_t b, logic bneq, word_t bImm);
        stimRow_t r;
        r       = blankRow();
        r.aluFn = fn;
        r.opA   = a;
        r.opB   = b;
        r.btype = 1'b1;
        r.bneq  = bneq;
        r.bImm  = bImm;
        rows.push_back(r);
    endtask

    // branch fields set too, so the jump must win over a taken branch
    task automatic putJump(logic j, logic jr, word_t a, word_t b, word_t jImm);
        stimRow_t r;
        r       = blankRow();
        r.aluFn = SUB;
        r.opA   = a;
        r.opB   = b;
        r.btype = 1'b1;
        r.bneq  = 1'b1;
        r.bImm  = 32'h40;
        r.jImm  = jImm;
        r.j     = j;
        r.jr    = jr;
        rows.push_back(r);
    endtask

    task automatic putMem(memOp_t op, word_t a, word_t b, word_t s);
        stimRow_t r;
        r       = blankRow();
        r.memOp = op;
        r.opA   = a;
        r.opB   = b;   // store data or load offset
        r.sImm  = s;
        rows.push_back(r);
    endtask

    task automatic buildTable();
        int fnIdx;
        putAlu(ADD, 32'd5, 32'd7);
        putAlu(ADD, 32'hffff_ffff, 32'd1);
        putAlu(SUB, 32'd3, 32'd5);
        putAlu(SLL, 32'h0000_0001, 32'h23);          // only shamt 3 counts
        putAlu(SLT, 32'hffff_ffff, 32'd1);
        putAlu(SLTU, 32'hffff_ffff, 32'd1);
        putAlu(XOR, 32'hf0f0_1234, 32'h0ff0_4321);
        putAlu(SRL, 32'h8000_0000, 32'd4);
        putAlu(SRA, 32'h8000_0000, 32'd4);
        putAlu(SRA, 32'hf000_0000, 32'h3f);
        putAlu(OR, 32'h00ff_0000, 32'h0000_00ff);
        putAlu(AND, 32'hdead_beef, 32'h0ff0_0ff0);
        putBranch(SUB, 32'd5, 32'd5, 1'b0, 32'h80);     // beq taken
        putBranch(SUB, 32'd5, 32'd6, 1'b0, 32'h80);     // beq falls through
        putBranch(SUB, 32'd5, 32'd6, 1'b1, 32'hffff_fff0);
        putBranch(SLT, 32'hffff_fffe, 32'd1, 1'b1, 32'h20);
        putBranch(SLTU, 32'd1, 32'hffff_ffff, 1'b0, 32'h20);
        putJump(1'b1, 1'b0, 32'd1, 32'd2, 32'h7f0);
        putJump(1'b0, 1'b1, 32'h1000, 32'h5, 32'h7f0);
        putJump(1'b1, 1'b1, 32'h2001, 32'h0, 32'h7f0);
        putMem(SW, 32'h0c, 32'h1122_3344, 32'd4);
        putMem(LW, 32'h10, 32'd0, 32'd0);               // right behind the store
        putMem(SB, 32'h10, 32'h0000_00aa, 32'd1);
        putMem(LB, 32'h10, 32'd1, 32'd0);
        putMem(LBU, 32'h11, 32'd0, 32'd0);
        putMem(SH, 32'h10, 32'h0000_8001, 32'd2);
        putAlu(ADD, 32'd1, 32'd1);
        putMem(LH, 32'h12, 32'd0, 32'd0);
        putMem(LHU, 32'h10, 32'd2, 32'd0);
        putMem(LW, 32'h10, 32'd0, 32'd0);
        putMem(LH, 32'h13, 32'd0, 32'd0);               // odd half address
        putMem(SW, 32'h20, 32'hdead_beef, 32'd2);
        putMem(SH, 32'h10, 32'h0000_ffff, 32'd1);
        putMem(LW, 32'h20, 32'd0, 32'd0);
        putMem(LW, 32'h14, 32'd2, 32'd0);
        putMem(LW, 32'h10, 32'd0, 32'd0);
        putMem(SW, 32'h400, 32'hcafe_f00d, 32'h10);     // wraps onto word 4
        putMem(LW, 32'h10, 32'd0, 32'd0);
        putBranch(SUB, 32'd9, 32'd9, 1'b1, 32'h10);
        putMem(LBU, 32'h13, 32'd0, 32'd0);
        for (int i = 0; i < RANDOM_ROWS; i++)
        begin
            fnIdx = $unsigned($random(seed)) % 10;
            putAlu(aluFn_t'(fnIdx[3:0]), $random(seed), $random(seed));
        end
    endtask

    task automatic driveRow(stimRow_t r);
        we4       = r.we;
        bneq4     = r.bneq;
        btype4    = r.btype;
        fn4       = r.fn;
        rd4       = r.rd;
        aluFn4    = r.aluFn;
        opA4      = r.opA;
        opB4      = r.opB;
        pc4       = r.pc;
        bImm4     = r.bImm;
        jImm4     = r.jImm;
        sImm4     = r.sImm;
        pcSelect4 = r.pcSel;
        j4        = r.j;
        jr4       = r.jr;
        memOp4    = r.memOp;
    endtask

    task automatic checkStage5(stimRow_t r);
        checkWord("aluRes5", aluRes5, r.expAlu);
        checkWord("target", target, r.expTarget);
        checkReg("rd5", rd5, r.rd);
        checkBit("we5", we5, r.we);
        checkFunct3("fn5", fn5, r.fn);
        checkPcSel("pcSelect5", pcSelect5, r.pcSel);
        checkBit("j5", j5, r.j);
        checkBit("jr5", jr5, r.jr);
    endtask

    task automatic checkMemory(stimRow_t r);
        checkWord("memOut6", memOut6, r.expMem);
        checkBit("addrMisaligned6", addrMisaligned6, r.expMis);
    endtask

    initial
    begin
        stimRow_t r;
        int       n;
        clk     = 1'b0;
        nrst    = 1'b0;
        seed    = 21;
        cycles  = 0;
        lastOut = 32'h0;
        idleRow = '0;
        idleRow.expAlu    = refAlu(idleRow.aluFn, idleRow.opA, idleRow.opB);
        idleRow.expTarget = refTarget(idleRow);
        driveRow(idleRow);
        for (int i = 0; i < DMEM_WORDS; i++)
        begin
            shadow[i] = 32'h0;
        end
        buildTable();
        n = rows.size();
        for (int i = 0; i < n; i++)
        begin
            r           = rows[i];
            r.expAlu    = refAlu(r.aluFn, r.opA, r.opB);
            r.expTarget = refTarget(r);
            modelMem(r);
            rows[i]     = r;
        end
        cycleLimit = n + 2 + RESET_CYCLES + 20;

        repeat (RESET_CYCLES) @(negedge clk);
        // cleared pipe reads as an ADD of zeros at pc 0
        checkStage5(idleRow);
        checkMemory(idleRow);
        nrst = 1'b1;

        for (int i = 0; i < n + 2; i++)
        begin
            @(negedge clk);
            if (i >= 1 && i <= n)
            begin
                checkStage5(prev1);
            end
            if (i >= 2)
            begin
                checkMemory(prev2);
            end
            prev2 = prev1;
            prev1 = (i < n) ? rows[i] : idleRow;
            driveRow(prev1);
        end

        $display("=== PASS ===");
        $finish;
    end

endmodule
